// ==== vlog.f ====
logic/bitstat_op_pkg.sv
logic/bitstat_res_pkg.sv
logic/bit_population_counter.sv
logic/bitstat_prep.sv
logic/bitstat_count_stage.sv
logic/bitstat_format.sv
logic/bitstat_top.sv
dv/bitstat_assertions.sv
dv/bitstat_tb.sv

// ==== Bender.yml ====
package:
  name: bitstat

sources:
  - files:
      - logic/bitstat_op_pkg.sv
      - logic/bitstat_res_pkg.sv
      - logic/bit_population_counter.sv
      - logic/bitstat_prep.sv
      - logic/bitstat_count_stage.sv
      - logic/bitstat_format.sv
      - logic/bitstat_top.sv
  - target: test
    files:
      - dv/bitstat_assertions.sv
      - dv/bitstat_tb.sv

// ==== dv/bitstat_tb.sv ====
module bitstat_tb
  import bitstat_op_pkg::*;
  import bitstat_res_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WIDTH        = 32;
  localparam int CNT_W        = $clog2(WIDTH) + 2;
  localparam int LATENCY      = $clog2(WIDTH) + 3;
  localparam int RESET_CYCLES = 10;
  localparam int N_RAND       = 24;                 // requests in each random test
  localparam int N_REQ        = 42 + 4 * N_RAND;    // corner, random, reset and isolated requests
  localparam int TIMEOUT      = N_REQ * (LATENCY + 3) + 10 * LATENCY + 2 * RESET_CYCLES + 200;

  typedef struct packed {
    logic [CNT_W-1:0] data;
    bitstat_flags_t   flags;
    bitstat_tag_t     tag;
    logic [31:0]      issue; // cycle count on the edge that drove the request
  } expect_t;

  logic              clk_i = 1'b0;
  logic              srst_i;
  logic              req_valid_i;
  bitstat_req_ctrl_t req_ctrl_i;
  logic [WIDTH-1:0]  req_a_i;
  logic [WIDTH-1:0]  req_b_i;
  logic              res_valid_o;
  logic [CNT_W-1:0]  res_data_o;
  bitstat_res_ctrl_t res_ctrl_o;

  expect_t      exp_q[$];
  logic [31:0]  lfsr;
  bitstat_tag_t next_tag;
  string        test_name = "reset";
  int unsigned  cycle = 0;
  int unsigned  checks = 0;
  int unsigned  errors = 0;
  int unsigned  timeouts = 0;

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i)
    cycle <= cycle + 1;

  bitstat_top #(
    .WIDTH       ( WIDTH       )
  ) dut (
    .clk_i       ( clk_i       ),
    .srst_i      ( srst_i      ),
    .req_valid_i ( req_valid_i ),
    .req_ctrl_i  ( req_ctrl_i  ),
    .req_a_i     ( req_a_i     ),
    .req_b_i     ( req_b_i     ),
    .res_valid_o ( res_valid_o ),
    .res_data_o  ( res_data_o  ),
    .res_ctrl_o  ( res_ctrl_o  )
  );

  // ****************************************
  // random source and reference model
  // ****************************************

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // counts bit by bit from the operation's definition
  function automatic expect_t model(input bitstat_op_e op, input logic [WIDTH-1:0] a,
                                    input logic [WIDTH-1:0] b);
    expect_t e;
    int      n;
    logic    seen;
    e    = '0;
    n    = 0;
    seen = 1'b0;
    for (int i = WIDTH - 1; i >= 0; i--)
    begin
      case (op)
        OP_HAMMING: n += (a[i] != b[i]);
        OP_CLZ:
        begin
          seen = seen | a[i];            // walks down from the top bit
          n += !seen;
        end
        OP_CTZ:
        begin
          seen = seen | a[WIDTH - 1 - i]; // walks up from bit zero
          n += !seen;
        end
        default:    n += a[i];
      endcase
    end
    if (op == OP_PARITY)
      n = n % 2;
    e.data       = CNT_W'(n);
    e.flags.zero = (n == 0);
    e.flags.full = (n == WIDTH);
    return e;
  endfunction

  // ****************************************
  // driving and checking
  // ****************************************

  task automatic send(input bitstat_op_e op, input logic [WIDTH-1:0] a,
                      input logic [WIDTH-1:0] b);
    expect_t e;
    @(negedge clk_i);
    e       = model(op, a, b);
    e.tag   = next_tag;
    e.issue = cycle;
    exp_q.push_back(e);
    req_valid_i    = 1'b1;
    req_ctrl_i.op  = op;
    req_ctrl_i.tag = next_tag;
    req_a_i        = a;
    req_b_i        = b;
    next_tag++;
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(negedge clk_i);
      req_valid_i = 1'b0;
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_q.size() != 0)
      @(negedge clk_i);
  endtask

  task automatic apply_reset(input int n);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    srst_i      = 1'b1;
    repeat (n) @(negedge clk_i);
    exp_q.delete(); // requests in flight are flushed by the reset
    srst_i = 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic finish_run();
    int unsigned assert_errors;
    assert_errors = dut.u_assertions.assert_errors;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, assert_errors);
    if (errors == 0 && timeouts == 0 && assert_errors == 0 && checks > 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  endtask

  // outputs change on the rising edge and are read on the falling one
  always @(negedge clk_i)
  begin
    expect_t e;
    if (res_valid_o)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("ERROR %s: a result arrived with no request outstanding", test_name);
      end
      else
      begin
        e = exp_q.pop_front();
        if (res_ctrl_o.tag !== e.tag)
        begin
          errors++;
          $display("ERROR %s: out-of-order result, tag %0h arrived where tag %0h was due",
                   test_name, res_ctrl_o.tag, e.tag);
        end
        check_value("result", e.data, res_data_o);
        check_value("flags", e.flags, res_ctrl_o.flags);
        check_value("latency", LATENCY, cycle - e.issue);
      end
    end
  end

  initial
  begin
    repeat (TIMEOUT) @(posedge clk_i);
    timeouts++;
    $display("ERROR: watchdog expired after %0d cycles with results still missing", TIMEOUT);
    finish_run();
  end

  // ****************************************
  // stimulus
  // ****************************************

  initial
  begin
    logic [31:0]      r;
    logic [31:0]      s;
    logic [31:0]      g;
    logic [WIDTH-1:0] corners [5];
    corners     = '{32'h0000_0000, 32'hffff_ffff, 32'h0000_0001, 32'h8000_0000, 32'haaaa_aaaa};
    lfsr        = 32'h00d514bc;
    next_tag    = '0;
    srst_i      = 1'b1;
    req_valid_i = 1'b0;
    req_ctrl_i  = '0;
    req_a_i     = '0;
    req_b_i     = '0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    srst_i = 1'b0;

    test_name = "corner";
    for (int k = 0; k < 5; k++)
      for (int w = 0; w < 5; w++)
        send(bitstat_op_e'(k), corners[w], '0);
    drain();

    test_name = "popcount_parity";
    for (int k = 0; k < N_RAND; k++)
    begin
      take_bits(1, s);
      take_bits(WIDTH, r);
      send(s[0] ? OP_PARITY : OP_POPCNT, r, '0);
    end
    drain();

    test_name = "hamming";
    for (int k = 0; k < N_RAND; k++)
    begin
      take_bits(WIDTH, r);
      take_bits(WIDTH, s);
      if (k % 4 == 0)
        s = r;            // distance zero
      else if (k % 4 == 1)
        s = ~r;           // distance equals the width
      send(OP_HAMMING, r, s);
    end
    drain();

    test_name = "clz_ctz";
    for (int k = 0; k < N_RAND; k++)
    begin
      take_bits(WIDTH, r);
      take_bits(6, s);
      r = s[5] ? r << s[4:0] : r >> s[4:0]; // spreads the zero runs over the whole range
      send(s[5] ? OP_CTZ : OP_CLZ, r, '0);
    end
    drain();

    test_name = "gaps";
    for (int k = 0; k < N_RAND + 6; k++)
    begin
      take_bits(3, s);
      take_bits(WIDTH, r);
      take_bits(WIDTH, g);
      send(bitstat_op_e'(s % 5), r, g);
      if (k == 5)
      begin
        test_name = "reset";
        apply_reset(3);
      end
      take_bits(3, g);
      idle(g);
    end
    drain();

    test_name = "latency";
    for (int k = 0; k < 5; k++)
    begin
      take_bits(WIDTH, r);
      send(OP_POPCNT, r, '0);
      idle(LATENCY + 2);
    end
    drain();
    finish_run();
  end

endmodule

// ==== dv/bitstat_assertions.sv ====
module bitstat_assertions #(
  parameter int WIDTH = 32
)(
  input  logic clk_i,
  input  logic srst_i,
  input  logic req_valid_i,
  input  logic res_valid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LATENCY = $clog2(WIDTH) + 3; // prep, counter tree and format registers

  int unsigned req_count;
  int unsigned res_count;
  int unsigned assert_errors = 0; // read by the testbench for its closing report

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      req_count <= 0;
      res_count <= 0;
    end
    else
    begin
      req_count <= req_count + req_valid_i;
      res_count <= res_count + res_valid_i;
    end
  end

  // ****************************************
  // handshake properties
  // ****************************************

  quiet_in_reset: assert property (@(posedge clk_i) srst_i |=> !res_valid_i)
    else
    begin
      $error("res_valid_o is high while the unit is held in reset");
      assert_errors++;
    end

  no_extra_result: assert property (@(posedge clk_i) disable iff (srst_i)
    (res_count + res_valid_i) <= (req_count + req_valid_i))
    else
    begin
      $error("more results have left the unit than requests entered it");
      assert_errors++;
    end

  fixed_latency: assert property (@(posedge clk_i) disable iff (srst_i)
    req_valid_i |-> ##LATENCY res_valid_i)
    else
    begin
      $error("a request produced no result exactly %0d cycles later", LATENCY);
      assert_errors++;
    end

endmodule

bind bitstat_top bitstat_assertions #(
  .WIDTH       ( WIDTH       )
) u_assertions (
  .clk_i       ( clk_i       ),
  .srst_i      ( srst_i      ),
  .req_valid_i ( req_valid_i ),
  .res_valid_i ( res_valid_o )
);

// ==== logic/bitstat_top.sv ====
module bitstat_top
  import bitstat_op_pkg::*;
  import bitstat_res_pkg::*;
#(
  parameter int WIDTH = 32
)(
  input  logic                      clk_i,
  input  logic                      srst_i,
  input  logic                      req_valid_i,
  input  bitstat_req_ctrl_t         req_ctrl_i,
  input  logic [WIDTH-1:0]          req_a_i,
  input  logic [WIDTH-1:0]          req_b_i,

  output logic                      res_valid_o,
  output logic [$clog2(WIDTH)+1:0]  res_data_o,
  output bitstat_res_ctrl_t         res_ctrl_o
);

  localparam int CNT_W = $clog2(WIDTH) + 2;

  // ****************************************
  // inter stage signals
  // ****************************************

  logic              prep_valid;
  bitstat_req_ctrl_t prep_ctrl;
  logic [WIDTH-1:0]  prep_word;  // transformed operand, ready for counting

  logic              cnt_valid;
  bitstat_req_ctrl_t cnt_ctrl;
  logic [CNT_W-1:0]  cnt_count;

  bitstat_prep #(
    .WIDTH   ( WIDTH       )
  ) u_prep (
    .clk_i   ( clk_i       ),
    .srst_i  ( srst_i      ),
    .valid_i ( req_valid_i ),
    .ctrl_i  ( req_ctrl_i  ),
    .a_i     ( req_a_i     ),
    .b_i     ( req_b_i     ),
    .valid_o ( prep_valid  ),
    .ctrl_o  ( prep_ctrl   ),
    .word_o  ( prep_word   )
  );

  bitstat_count_stage #(
    .WIDTH   ( WIDTH      )
  ) u_count (
    .clk_i   ( clk_i      ),
    .srst_i  ( srst_i     ),
    .valid_i ( prep_valid ),
    .ctrl_i  ( prep_ctrl  ),
    .word_i  ( prep_word  ),
    .valid_o ( cnt_valid  ),
    .ctrl_o  ( cnt_ctrl   ),
    .count_o ( cnt_count  )
  );

  bitstat_format #(
    .WIDTH   ( WIDTH       )
  ) u_format (
    .clk_i   ( clk_i       ),
    .srst_i  ( srst_i      ),
    .valid_i ( cnt_valid   ),
    .ctrl_i  ( cnt_ctrl    ),
    .count_i ( cnt_count   ),
    .valid_o ( res_valid_o ),
    .data_o  ( res_data_o  ),
    .ctrl_o  ( res_ctrl_o  )
  );

endmodule

// ==== logic/bitstat_format.sv ====
module bitstat_format
  import bitstat_op_pkg::*;
  import bitstat_res_pkg::*;
#(
  parameter int WIDTH = 32
)(
  input  logic                      clk_i,
  input  logic                      srst_i,
  input  logic                      valid_i,
  input  bitstat_req_ctrl_t         ctrl_i,
  input  logic [$clog2(WIDTH)+1:0]  count_i,

  output logic                      valid_o,
  output logic [$clog2(WIDTH)+1:0]  data_o,
  output bitstat_res_ctrl_t         ctrl_o
);

  localparam int CNT_W = $clog2(WIDTH) + 2;

  logic [CNT_W-1:0] result; // final value before the output register
  bitstat_flags_t   flags;

  // ****************************************
  // result selection
  // ****************************************

  always_comb
  begin
    case (ctrl_i.op)
      OP_PARITY: result = CNT_W'(count_i[0]);         // odd count means odd parity
      OP_CLZ:    result = CNT_W'(WIDTH) - count_i;    // smeared word counts the bits from the top one down
      default:   result = count_i;
    endcase
  end

  assign flags.zero = (result == '0);
  assign flags.full = (result == CNT_W'(WIDTH));

  // output register
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      valid_o <= 1'b0;
      data_o  <= '0;
      ctrl_o  <= '0;
    end
    else
    begin
      valid_o <= valid_i;
      if (valid_i)
      begin
        data_o       <= result;
        ctrl_o.tag   <= ctrl_i.tag;
        ctrl_o.flags <= flags;
      end
      else
      begin
        data_o <= '0;
        ctrl_o <= '0;
      end
    end
  end

endmodule

// ==== logic/bitstat_count_stage.sv ====
module bitstat_count_stage
  import bitstat_op_pkg::*;
#(
  parameter int WIDTH = 32
)(
  input  logic                      clk_i,
  input  logic                      srst_i,
  input  logic                      valid_i,
  input  bitstat_req_ctrl_t         ctrl_i,
  input  logic [WIDTH-1:0]          word_i,

  output logic                      valid_o,
  output bitstat_req_ctrl_t         ctrl_o,
  output logic [$clog2(WIDTH)+1:0]  count_o
);

  localparam int LAT = $clog2(WIDTH) + 1; // leaf register plus one register per merge level

  bitstat_req_ctrl_t [LAT-1:0] ctrl_pipe; // entry k holds the control of the word k+1 cycles deep

  // ****************************************
  // counter tree
  // ****************************************

  bit_population_counter #(
    .WIDTH      ( WIDTH   )
  ) u_counter (
    .clk_i      ( clk_i   ),
    .srst_i     ( srst_i  ),
    .data_i     ( word_i  ),
    .data_val_i ( valid_i ),
    .data_o     ( count_o ),
    .data_val_o ( valid_o )
  );

  // control delay line, same depth as the tree so op and tag meet their count
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
      ctrl_pipe <= '0;
    else
    begin
      ctrl_pipe[0] <= valid_i ? ctrl_i : '0;
      for (int k = 1; k < LAT; k++)
        ctrl_pipe[k] <= ctrl_pipe[k-1];
    end
  end

  assign ctrl_o = ctrl_pipe[LAT-1];

endmodule

// ==== logic/bitstat_prep.sv ====
module bitstat_prep
  import bitstat_op_pkg::*;
#(
  parameter int WIDTH = 32
)(
  input  logic              clk_i,
  input  logic              srst_i,
  input  logic              valid_i,
  input  bitstat_req_ctrl_t ctrl_i,
  input  logic [WIDTH-1:0]  a_i,
  input  logic [WIDTH-1:0]  b_i,

  output logic              valid_o,
  output bitstat_req_ctrl_t ctrl_o,
  output logic [WIDTH-1:0]  word_o
);

  logic [WIDTH-1:0] smear;     // every bit at or below the highest set bit of a is set
  logic [WIDTH-1:0] low_zeros; // ones where a has zeros below its lowest set bit
  logic [WIDTH-1:0] word_next; // word handed to the counter tree

  // ****************************************
  // operand transforms
  // ****************************************

  always_comb
  begin
    smear = a_i;
    for (int s = 1; s < WIDTH; s = s * 2)
      smear = smear | (smear >> s); // doubling shifts reach bit zero in log steps
  end

  assign low_zeros = ~a_i & (a_i - 1'b1); // an all zero a gives all ones

  always_comb
  begin
    case (ctrl_i.op)
      OP_HAMMING: word_next = a_i ^ b_i;
      OP_CLZ:     word_next = smear;     // format stage subtracts this count from the width
      OP_CTZ:     word_next = low_zeros;
      default:    word_next = a_i;       // popcount and parity count a directly
    endcase
  end

  // ****************************************
  // stage register
  // ****************************************

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      valid_o <= 1'b0;
      ctrl_o  <= '0;
      word_o  <= '0;
    end
    else
    begin
      valid_o <= valid_i;
      ctrl_o  <= valid_i ? ctrl_i : '0;    // idle cycles carry zeros down the pipe
      word_o  <= valid_i ? word_next : '0;
    end
  end

endmodule

// ==== logic/bit_population_counter.sv ====
module bit_population_counter #(
  parameter int WIDTH = 32
)(
  input  logic                       clk_i,
  input  logic                       srst_i,
  input  logic [WIDTH-1:0]           data_i,
  input  logic                       data_val_i,

  output logic [$clog2(WIDTH)+1:0]   data_o,
  output logic                       data_val_o
);

  localparam int CNT_W      = $clog2(WIDTH) + 2;
  localparam int REAL_W     = 1 << $clog2(WIDTH);           // width rounded up to a power of two
  localparam int HALF_W     = (REAL_W > 1) ? REAL_W / 2 : 1;
  localparam int HALF_CNT_W = $clog2(HALF_W) + 2;           // count width of each half

  generate
    if (WIDTH == 1)
    begin : g_leaf

      // ****************************************
      // single bit leaf
      // ****************************************

      always_ff @(posedge clk_i)
      begin
        if (srst_i)
        begin
          data_val_o <= 1'b0;
          data_o     <= '0;
        end
        else
        begin
          data_val_o <= data_val_i;
          if (data_val_i)
            data_o <= CNT_W'(data_i); // the count of one bit is the bit itself
          else
            data_o <= '0;
        end
      end

    end
    else
    begin : g_node

      logic [REAL_W-1:0]              padded_data; // upper bits beyond WIDTH are zero
      logic [1:0][HALF_CNT_W-1:0]     half_cnt;
      logic [1:0]                     half_val;

      assign padded_data = REAL_W'(data_i);

      // ****************************************
      // two recursive halves
      // ****************************************

      for (genvar i = 0; i < 2; i++)
      begin : g_half
        bit_population_counter #(
          .WIDTH      ( HALF_W                          )
        ) u_half (
          .clk_i      ( clk_i                           ),
          .srst_i     ( srst_i                          ),
          .data_i     ( padded_data[i*HALF_W +: HALF_W] ), // half zero is the low half
          .data_val_i ( data_val_i                      ),
          .data_o     ( half_cnt[i]                     ),
          .data_val_o ( half_val[i]                     )
        );
      end

      // both halves have equal depth so their valids arrive together
      always_ff @(posedge clk_i)
      begin
        if (srst_i)
        begin
          data_val_o <= 1'b0;
          data_o     <= '0;
        end
        else
        begin
          data_val_o <= &half_val;
          if (&half_val)
            data_o <= CNT_W'(half_cnt[0]) + CNT_W'(half_cnt[1]);
          else
            data_o <= '0;
        end
      end

    end
  endgenerate

endmodule

// ==== logic/bitstat_res_pkg.sv ====
package bitstat_res_pkg;

  import bitstat_op_pkg::*;

  // ****************************************
  // result side types
  // ****************************************

  typedef struct packed {
    logic zero; // the result is zero
    logic full; // the result equals the word width
  } bitstat_flags_t;

  // control fields that leave the unit with each result
  typedef struct packed {
    bitstat_tag_t   tag;   // copied from the request
    bitstat_flags_t flags; // computed from the final result
  } bitstat_res_ctrl_t;

endpackage

// ==== logic/bitstat_op_pkg.sv ====
package bitstat_op_pkg;

  // ****************************************
  // request side types
  // ****************************************

  localparam int TAG_W = 4; // width of the requester chosen identifier

  typedef logic [TAG_W-1:0] bitstat_tag_t;

  // operation codes, every one of them is reduced to a population count
  typedef enum logic [2:0] {
    OP_POPCNT  = 3'd0, // number of set bits in a
    OP_PARITY  = 3'd1, // xor of all bits in a
    OP_HAMMING = 3'd2, // number of differing bits between a and b
    OP_CLZ     = 3'd3, // leading zeros of a
    OP_CTZ     = 3'd4  // trailing zeros of a
  } bitstat_op_e;

  // control fields that follow each word through the pipeline
  typedef struct packed {
    bitstat_op_e  op;  // requested operation
    bitstat_tag_t tag; // returned unchanged with the result
  } bitstat_req_ctrl_t;

endpackage
